// ==== src/rs_consts.svh ====
// Reservation station sizes, included by the package and every RTL file that needs them
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Station geometry
////////////////////////////////////////////////////////////////////////////

// Entries in the station
`define RS_ENTRIES 8

////////////////////////////////////////////////////////////////////////////
// Machine sizes seen by the station
////////////////////////////////////////////////////////////////////////////

`define PRF_SIZE   64   // Physical registers, sets tag width
`define ROB_SIZE   32   // ROB entries, sets ROB index width

// Operand and CDB data width
`define XLEN       64

`endif

// ==== src/rs_pkg.sv ====
// Shared types for the reservation station, referenced as rs_pkg::name by every module
`include "rs_consts.svh"

package rs_pkg;

	typedef enum logic [3:0]
	{
		alu_default = 4'h0,         // Plain add
		alu_sub     = 4'h1,
		alu_and     = 4'h2,
		alu_or      = 4'h3,
		alu_xor     = 4'h4,
		alu_sll     = 4'h5,
		alu_srl     = 4'h6,
		alu_sra     = 4'h7,
		alu_slt     = 4'h8,
		alu_sltu    = 4'h9
	} alu_func_t;

	typedef enum logic [1:0]
	{
		fu_default = 2'd0,          // Integer ALU
		fu_mult    = 2'd1,
		fu_mem     = 2'd2,
		fu_branch  = 2'd3
	} fu_select_t;

	typedef logic [$clog2(`PRF_SIZE)-1:0] prf_tag_t;    // Physical register tag
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;    // ROB slot

	// Value when valid, else low bits hold the awaited tag
	typedef struct packed
	{
		logic [`XLEN-1:0] data;
		logic             valid;
	} operand_t;

	typedef struct packed
	{
		logic       valid;          // Slot carries an instruction
		operand_t   opa;
		operand_t   opb;
		prf_tag_t   dest;           // Result register
		rob_idx_t   rob_idx;
		logic [5:0] op_type;
		alu_func_t  alu_func;
		fu_select_t fu_sel;
	} disp_pkt_t;

	typedef struct packed
	{
		logic             valid;    // Broadcast this cycle
		prf_tag_t         tag;
		logic [`XLEN-1:0] data;
	} cdb_t;

	typedef struct packed
	{
		logic [`XLEN-1:0] opa;      // Resolved operand values
		logic [`XLEN-1:0] opb;
		prf_tag_t         dest;
		rob_idx_t         rob_idx;
		logic [5:0]       op_type;
		alu_func_t        alu_func;
		fu_select_t       fu_sel;
	} issue_pkt_t;

endpackage

// ==== src/rs_entry.sv ====
// One reservation station entry, loaded by dispatch, woken by both CDBs, freed by select
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_entry
(
	input  logic               clock,
	input  logic               reset,
	input  logic               load,       // Dispatch writes this entry
	input  rs_pkg::disp_pkt_t  disp,       // Packet steered here
	input  rs_pkg::cdb_t       cdb0,       // Result bus 0
	input  rs_pkg::cdb_t       cdb1,       // Result bus 1, wins on a tie
	input  logic               free,       // Picked by select this cycle
	output logic               busy,       // Entry holds an instruction
	output logic               ready,      // Both operands present
	output rs_pkg::issue_pkt_t held        // Stored instruction
);

	localparam int TAG_W = $clog2(`PRF_SIZE);

	rs_pkg::operand_t   opa_q;             // Operand A, value or tag
	rs_pkg::operand_t   opb_q;             // Operand B, value or tag
	rs_pkg::operand_t   opa_nxt;
	rs_pkg::operand_t   opb_nxt;
	rs_pkg::prf_tag_t   dest_q;
	rs_pkg::rob_idx_t   rob_q;
	logic [5:0]         op_type_q;
	rs_pkg::alu_func_t  alu_func_q;
	rs_pkg::fu_select_t fu_sel_q;

	////////////////////////////////////////////////////////////////////////////
	// Wakeup
	////////////////////////////////////////////////////////////////////////////

	// Capture a broadcast whose tag matches a waiting operand
	function automatic rs_pkg::operand_t wake
	(
		input rs_pkg::operand_t op,
		input rs_pkg::cdb_t     bus0,
		input rs_pkg::cdb_t     bus1
	);
		rs_pkg::operand_t res;
		res = op;
		if (!op.valid && bus0.valid && bus0.tag == op.data[TAG_W-1:0])
		begin
			res.data  = bus0.data;
			res.valid = 1'b1;
		end
		if (!op.valid && bus1.valid && bus1.tag == op.data[TAG_W-1:0])
		begin
			res.data  = bus1.data;             // Later check, so cdb1 wins
			res.valid = 1'b1;
		end
		return res;
	endfunction

	always_comb
	begin
		if (load)
		begin
			opa_nxt = disp.opa;                // Load beats any broadcast
			opb_nxt = disp.opb;
		end
		else if (busy)
		begin
			opa_nxt = wake(opa_q, cdb0, cdb1);
			opb_nxt = wake(opb_q, cdb0, cdb1);
		end
		else
		begin
			opa_nxt = opa_q;                   // Idle entry keeps stale state
			opb_nxt = opb_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			busy <= 1'b0;
		else if (load)
			busy <= 1'b1;
		else if (free)
			busy <= 1'b0;                      // Issue register took it
	end

	always_ff @(posedge clock)
	begin
		opa_q <= opa_nxt;
		opb_q <= opb_nxt;
		if (load)
		begin
			dest_q     <= disp.dest;
			rob_q      <= disp.rob_idx;
			op_type_q  <= disp.op_type;
			alu_func_q <= disp.alu_func;
			fu_sel_q   <= disp.fu_sel;
		end
	end

	assign ready = busy && opa_q.valid && opb_q.valid;

	always_comb
	begin
		held.opa      = opa_q.data;
		held.opb      = opb_q.data;
		held.dest     = dest_q;
		held.rob_idx  = rob_q;
		held.op_type  = op_type_q;
		held.alu_func = alu_func_q;
		held.fu_sel   = fu_sel_q;
	end

endmodule

// ==== src/rs_alloc.sv ====
// Dispatch allocation, places up to two new instructions into the lowest free entries
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_alloc
(
	input  rs_pkg::disp_pkt_t      disp0,                     // Dispatch slot 0
	input  rs_pkg::disp_pkt_t      disp1,                     // Dispatch slot 1
	input  logic [`RS_ENTRIES-1:0] busy,                      // Occupied entries
	output logic [`RS_ENTRIES-1:0] load,                      // Per-entry write strobe
	output rs_pkg::disp_pkt_t      load_pkt [`RS_ENTRIES],    // Per-entry packet
	output logic                   disp_ready                 // Room for two
);

	localparam int IDX_W = $clog2(`RS_ENTRIES);
	localparam int CNT_W = $clog2(`RS_ENTRIES + 1);

	logic [IDX_W-1:0] first_idx;       // Lowest free entry
	logic [IDX_W-1:0] second_idx;      // Next free entry
	logic [IDX_W-1:0] slot1_idx;       // Where slot 1 lands
	logic             first_ok;
	logic             second_ok;
	logic [CNT_W-1:0] free_cnt;
	logic             load0;
	logic             load1;

	// First two free entries and free count
	always_comb
	begin
		first_idx  = '0;
		second_idx = '0;
		first_ok   = 1'b0;
		second_ok  = 1'b0;
		free_cnt   = '0;
		for (int i = 0; i < `RS_ENTRIES; i++)
		begin
			if (!busy[i])
			begin
				free_cnt = free_cnt + CNT_W'(1);
				if (!first_ok)
				begin
					first_idx = IDX_W'(i);
					first_ok  = 1'b1;
				end
				else if (!second_ok)
				begin
					second_idx = IDX_W'(i);
					second_ok  = 1'b1;
				end
			end
		end
	end

	assign load0      = disp0.valid && first_ok;
	assign slot1_idx  = disp0.valid ? second_idx : first_idx;     // Lone slot 1 takes the lowest
	assign load1      = disp1.valid && (disp0.valid ? second_ok : first_ok);
	assign disp_ready = free_cnt >= CNT_W'(2);

	// Steer packets to their entries
	always_comb
	begin
		for (int i = 0; i < `RS_ENTRIES; i++)
		begin
			load[i]     = (load0 && first_idx == IDX_W'(i)) || (load1 && slot1_idx == IDX_W'(i));
			load_pkt[i] = (load1 && slot1_idx == IDX_W'(i)) ? disp1 : disp0;
		end
	end

endmodule

// ==== src/rs_issue.sv ====
// Select and issue register, picks the lowest ready entry and holds it until the FU accepts
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_issue
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`RS_ENTRIES-1:0] ready,                     // Entries with both operands
	input  rs_pkg::issue_pkt_t     held [`RS_ENTRIES],        // Entry contents
	input  logic                   fu_ready,                  // FU takes the packet
	output logic [`RS_ENTRIES-1:0] free,                      // One-cycle release strobe
	output logic                   issue_valid,               // Issue register full
	output rs_pkg::issue_pkt_t     issue                      // Packet to the FU
);

	localparam int IDX_W = $clog2(`RS_ENTRIES);

	logic             can_load;        // Register empty or draining
	logic             sel_ok;          // Some entry is ready
	logic [IDX_W-1:0] sel_idx;         // Chosen entry

	assign can_load = !issue_valid || fu_ready;

	////////////////////////////////////////////////////////////////////////////
	// Select
	////////////////////////////////////////////////////////////////////////////

	// Scan down so the lowest index is left standing
	always_comb
	begin
		sel_ok  = 1'b0;
		sel_idx = '0;
		for (int i = `RS_ENTRIES - 1; i >= 0; i--)
		begin
			if (ready[i])
			begin
				sel_ok  = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < `RS_ENTRIES; i++)
			free[i] = can_load && sel_ok && sel_idx == IDX_W'(i);    // Same edge as load
	end

	////////////////////////////////////////////////////////////////////////////
	// Issue register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			issue_valid <= 1'b0;
		else if (can_load)
			issue_valid <= sel_ok;             // Drops when nothing replaces it
	end

	// Hold under back-pressure
	always_ff @(posedge clock)
	begin
		if (can_load && sel_ok)
			issue <= held[sel_idx];
	end

endmodule

// ==== src/rs_top.sv ====
// Reservation station top, wires dispatch allocation, the entry array and the issue stage
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_top
(
	input  logic               clock,
	input  logic               reset,
	input  rs_pkg::disp_pkt_t  disp0,          // From rename, slot 0
	input  rs_pkg::disp_pkt_t  disp1,          // From rename, slot 1
	input  rs_pkg::cdb_t       cdb0,           // Result broadcasts
	input  rs_pkg::cdb_t       cdb1,
	input  logic               fu_ready,       // FU back-pressure
	output logic               disp_ready,     // Two entries free
	output logic               issue_valid,
	output rs_pkg::issue_pkt_t issue
);

	logic [`RS_ENTRIES-1:0] busy;
	logic [`RS_ENTRIES-1:0] load;
	logic [`RS_ENTRIES-1:0] ready;
	logic [`RS_ENTRIES-1:0] free;
	rs_pkg::disp_pkt_t      load_pkt [`RS_ENTRIES];   // Alloc to entries
	rs_pkg::issue_pkt_t     held [`RS_ENTRIES];       // Entries to select

	rs_alloc alloc0
	(
		.disp0      (disp0),
		.disp1      (disp1),
		.busy       (busy),
		.load       (load),
		.load_pkt   (load_pkt),
		.disp_ready (disp_ready)
	);

	// Entry array, CDBs fan out unchanged
	for (genvar g = 0; g < `RS_ENTRIES; g++)
	begin : gen_entry
		rs_entry entry
		(
			.clock (clock),
			.reset (reset),
			.load  (load[g]),
			.disp  (load_pkt[g]),
			.cdb0  (cdb0),
			.cdb1  (cdb1),
			.free  (free[g]),
			.busy  (busy[g]),
			.ready (ready[g]),
			.held  (held[g])
		);
	end

	rs_issue issue0
	(
		.clock       (clock),
		.reset       (reset),
		.ready       (ready),
		.held        (held),
		.fu_ready    (fu_ready),
		.free        (free),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

endmodule

// ==== tb/rs_checker.sv ====
// Reference model and comparator for the reservation station, instanced by rs_tb beside dut0
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_checker
(
	input  logic               clock,
	input  logic               reset,
	input  rs_pkg::disp_pkt_t  disp0,
	input  rs_pkg::disp_pkt_t  disp1,
	input  rs_pkg::cdb_t       cdb0,
	input  rs_pkg::cdb_t       cdb1,
	input  logic               fu_ready,
	input  logic               disp_ready,
	input  logic               issue_valid,
	input  rs_pkg::issue_pkt_t issue,
	output int                 n_disp,         // Instructions seen entering
	output int                 n_issue,        // Instructions accepted by the FU
	output int                 n_errors,
	output int                 low_cycles      // Cycles with disp_ready low
);

	rs_pkg::disp_pkt_t    model [`ROB_SIZE];   // Expected instruction per ROB slot
	logic [`ROB_SIZE-1:0] live;                // Slot in flight
	logic                 reset_q;             // Previous edge was in reset
	logic                 hold_q;              // Previous cycle stalled with a packet
	rs_pkg::issue_pkt_t   last_issue;
	rs_pkg::issue_pkt_t   exp_pkt;
	int                   occ;                 // Entries the station should hold
	int                   r;

	task automatic report_mismatch(input string msg);
		n_errors++;
		$display("mismatch %0t: %s", $time, msg);
	endtask

	task automatic report_error(input string msg);
		n_errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	// Operand after one edge of snooping, cdb1 taking a tie
	function automatic rs_pkg::operand_t resolve
	(
		input rs_pkg::operand_t op,
		input rs_pkg::cdb_t     c0,
		input rs_pkg::cdb_t     c1
	);
		rs_pkg::prf_tag_t want;
		rs_pkg::operand_t res;
		want = rs_pkg::prf_tag_t'(op.data);   // Tag sits in the low bits
		res  = op;
		if (!op.valid && c1.valid && c1.tag == want)
			res = '{data: c1.data, valid: 1'b1};
		else if (!op.valid && c0.valid && c0.tag == want)
			res = '{data: c0.data, valid: 1'b1};
		return res;
	endfunction

	function automatic rs_pkg::issue_pkt_t expect_issue(input rs_pkg::disp_pkt_t p);
		rs_pkg::issue_pkt_t e;
		e.opa      = p.opa.data;
		e.opb      = p.opb.data;
		e.dest     = p.dest;
		e.rob_idx  = p.rob_idx;
		e.op_type  = p.op_type;
		e.alu_func = p.alu_func;
		e.fu_sel   = p.fu_sel;
		return e;
	endfunction

	task automatic record(input rs_pkg::disp_pkt_t p);
		if (p.valid)
		begin
			if (!disp_ready)
				report_error("dispatch sent while disp_ready was low");
			if (live[p.rob_idx])
				report_error($sformatf("ROB index %0d dispatched while still in flight", p.rob_idx));
			model[p.rob_idx] = p;
			live[p.rob_idx]  = 1'b1;
			n_disp++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-edge model update, issue first, then wakeup, then dispatch
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		if (reset)
		begin
			live       = '0;
			n_disp     = 0;
			n_issue    = 0;
			n_errors   = 0;
			low_cycles = 0;
			hold_q     = 1'b0;
			reset_q    = 1'b1;
		end
		else
		begin
			if (reset_q && (issue_valid !== 1'b0 || disp_ready !== 1'b1))
				report_mismatch($sformatf("after reset issue_valid %b disp_ready %b, expected 0 and 1",
					issue_valid, disp_ready));
			occ = n_disp - n_issue - (issue_valid ? 1 : 0);   // One sits in the issue register
			if (disp_ready !== ((`RS_ENTRIES - occ) >= 2))
				report_mismatch($sformatf("disp_ready %b with %0d entries busy", disp_ready, occ));
			if (!disp_ready)
				low_cycles++;
			if (hold_q && (!issue_valid || issue !== last_issue))
				report_mismatch("issue packet changed while fu_ready was low");
			hold_q     = issue_valid && !fu_ready;
			last_issue = issue;
			if (issue_valid && fu_ready)
			begin
				r = int'(issue.rob_idx);
				if (!live[r])
					report_error($sformatf("ROB index %0d issued but not in flight", r));
				else
				begin
					exp_pkt = expect_issue(model[r]);
					if (!model[r].opa.valid || !model[r].opb.valid)
						report_error($sformatf("ROB index %0d issued before its operands were broadcast", r));
					else if (issue !== exp_pkt)
						report_mismatch($sformatf("ROB %0d issued %h, expected %h", r, issue, exp_pkt));
					live[r] = 1'b0;
					n_issue++;
				end
			end
			for (int i = 0; i < `ROB_SIZE; i++)
			begin
				if (live[i])
				begin
					model[i].opa = resolve(model[i].opa, cdb0, cdb1);
					model[i].opb = resolve(model[i].opb, cdb0, cdb1);
				end
			end
			record(disp0);                     // Same-edge broadcasts already passed
			record(disp1);
			reset_q = 1'b0;
		end
	end

endmodule

// ==== tb/rs_asserts.sv ====
// Protocol assertions on the reservation station ports, bound into rs_top by the testbench
`timescale 1ns/1ns

module rs_asserts
(
	input logic               clock,
	input logic               reset,
	input rs_pkg::disp_pkt_t  disp0,
	input rs_pkg::disp_pkt_t  disp1,
	input logic               fu_ready,
	input logic               disp_ready,
	input logic               issue_valid,
	input rs_pkg::issue_pkt_t issue
);

	int fail_count = 0;                    // Read by the testbench top

	// Rename may only send into room for two
	no_disp_when_full: assert property (@(posedge clock) disable iff (reset)
		!disp_ready |-> !disp0.valid && !disp1.valid)
	else
	begin
		fail_count++;
		$error("dispatch valid while disp_ready is low");
	end

	// Stalled packet must not move
	hold_under_stall: assert property (@(posedge clock) disable iff (reset)
		issue_valid && !fu_ready |=> issue_valid && $stable(issue))
	else
	begin
		fail_count++;
		$error("issue packet or issue_valid changed while fu_ready was low");
	end

	empty_after_reset: assert property (@(posedge clock) reset |=> !issue_valid)
	else
	begin
		fail_count++;
		$error("issue_valid high in the cycle after reset");
	end

endmodule

// ==== tb/rs_tb.sv ====
// Testbench top for the reservation station, drives seeded random dispatch, CDB and FU traffic
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_tb;

	localparam int DRAIN_LIMIT = 300;                     // Cycles allowed to empty the station
	localparam int TAGS        = `PRF_SIZE;
	localparam int TAG_W       = $bits(rs_pkg::prf_tag_t);

	logic               clock;
	logic               reset;
	rs_pkg::disp_pkt_t  disp0;
	rs_pkg::disp_pkt_t  disp1;
	rs_pkg::cdb_t       cdb0;
	rs_pkg::cdb_t       cdb1;
	logic               fu_ready;
	logic               disp_ready;
	logic               issue_valid;
	rs_pkg::issue_pkt_t issue;

	int                   n_disp;
	int                   n_issue;
	int                   n_errors;
	int                   low_cycles;
	int                   tb_errors;          // Timeouts and coverage holes
	int                   total;
	int                   pct_disp;           // Odds per slot per cycle
	int                   pct_tag;            // Odds an operand waits on a tag
	int                   pct_cdb;            // Odds per bus per cycle
	int                   pct_fu;
	logic [`ROB_SIZE-1:0] rob_busy;           // ROB slots in flight
	logic [TAGS-1:0]      tag_busy;           // Tags awaiting broadcast
	int                   pend_q [$];         // Tags whose waiter dispatched earlier
	int                   fresh_q [$];        // Tags dispatched this cycle
	int                   next_rob;
	logic                 accept_q;           // FU takes the packet at the next edge
	rs_pkg::rob_idx_t     accept_rob;

	rs_top dut0
	(
		.clock       (clock),
		.reset       (reset),
		.disp0       (disp0),
		.disp1       (disp1),
		.cdb0        (cdb0),
		.cdb1        (cdb1),
		.fu_ready    (fu_ready),
		.disp_ready  (disp_ready),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	rs_checker checker0
	(
		.clock       (clock),
		.reset       (reset),
		.disp0       (disp0),
		.disp1       (disp1),
		.cdb0        (cdb0),
		.cdb1        (cdb1),
		.fu_ready    (fu_ready),
		.disp_ready  (disp_ready),
		.issue_valid (issue_valid),
		.issue       (issue),
		.n_disp      (n_disp),
		.n_issue     (n_issue),
		.n_errors    (n_errors),
		.low_cycles  (low_cycles)
	);

	bind rs_top rs_asserts asserts0
	(
		.clock       (clock),
		.reset       (reset),
		.disp0       (disp0),
		.disp1       (disp1),
		.fu_ready    (fu_ready),
		.disp_ready  (disp_ready),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;                 // 8 ns period

	function automatic logic roll(input int pct);
		return int'($urandom % 100) < pct;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic new_operand(output rs_pkg::operand_t op);
		int start;
		int t;
		t        = -1;
		start    = int'($urandom % TAGS);
		op.data  = {$urandom, $urandom};
		op.valid = 1'b1;
		if (roll(pct_tag))
		begin
			for (int k = 0; k < TAGS; k++)
			begin
				if (t < 0 && !tag_busy[(start + k) % TAGS])
					t = (start + k) % TAGS;
			end
		end
		if (t >= 0)
		begin
			tag_busy[t]            = 1'b1;
			op.valid               = 1'b0;
			op.data[TAG_W-1:0]     = rs_pkg::prf_tag_t'(t);     // Upper bits stay random
			fresh_q.push_back(t);
		end
	endtask

	task automatic new_instr(output rs_pkg::disp_pkt_t p);
		int               r;
		rs_pkg::operand_t a;
		rs_pkg::operand_t b;
		p = '0;
		r = -1;
		for (int k = 0; k < `ROB_SIZE; k++)
		begin
			if (r < 0 && !rob_busy[(next_rob + k) % `ROB_SIZE])
				r = (next_rob + k) % `ROB_SIZE;
		end
		if (r >= 0)
		begin
			new_operand(a);
			new_operand(b);
			rob_busy[r] = 1'b1;
			next_rob    = (r + 1) % `ROB_SIZE;
			p.valid     = 1'b1;
			p.opa       = a;
			p.opb       = b;
			p.dest      = rs_pkg::prf_tag_t'($urandom);
			p.rob_idx   = rs_pkg::rob_idx_t'(r);
			p.op_type   = 6'($urandom);
			p.alu_func  = rs_pkg::alu_func_t'(4'($urandom % 10));
			p.fu_sel    = rs_pkg::fu_select_t'(2'($urandom));
		end
	endtask

	task automatic broadcast(output rs_pkg::cdb_t c);
		int k;
		c = '0;
		if (pend_q.size() > 0 && roll(pct_cdb))
		begin
			k       = int'($urandom % pend_q.size());
			c.valid = 1'b1;
			c.tag   = rs_pkg::prf_tag_t'(pend_q[k]);
			c.data  = {$urandom, $urandom};
			tag_busy[pend_q[k]] = 1'b0;
			pend_q.delete(k);
		end
	endtask

	// One clock of traffic, driven just after the edge
	task automatic cycle();
		@(posedge clock);
		#1;
		if (accept_q)
			rob_busy[accept_rob] = 1'b0;
		while (fresh_q.size() > 0)
			pend_q.push_back(fresh_q.pop_front());
		disp0    = '0;
		disp1    = '0;
		fu_ready = roll(pct_fu);
		if (disp_ready && roll(pct_disp))
			new_instr(disp0);
		if (disp_ready && roll(pct_disp))
			new_instr(disp1);
		broadcast(cdb0);                      // After dispatch, so fresh tags wait a cycle
		broadcast(cdb1);
		if (cdb0.valid && !cdb1.valid && roll(10))
		begin
			cdb1.valid = 1'b1;                // Same tag on both buses
			cdb1.tag   = cdb0.tag;
			cdb1.data  = {$urandom, $urandom};
		end
		accept_q   = issue_valid && fu_ready;
		accept_rob = issue.rob_idx;
	endtask

	task automatic run_phase
	(
		input int    num,
		input string name,
		input int    cycles,
		input int    pd,
		input int    pt,
		input int    pc,
		input int    pf,
		input logic  need_full
	);
		int err0;
		int low0;
		int waited;
		err0     = n_errors + tb_errors;
		low0     = low_cycles;
		pct_disp = pd;
		pct_tag  = pt;
		pct_cdb  = pc;
		pct_fu   = pf;
		repeat (cycles)
			cycle();
		pct_disp = 0;                         // Drain with a willing FU
		pct_cdb  = 50;
		pct_fu   = 100;
		waited   = 0;
		do
		begin
			cycle();                          // Last dispatch gets counted first
			waited++;
		end
		while (n_issue != n_disp && waited < DRAIN_LIMIT);
		if (n_issue != n_disp)
		begin
			tb_errors++;
			$display("error %0t: %0d instructions never issued within %0d drain cycles",
				$time, n_disp - n_issue, DRAIN_LIMIT);
		end
		if (need_full && low_cycles == low0)
		begin
			tb_errors++;
			$display("error %0t: disp_ready never dropped, the station never filled", $time);
		end
		$display("test %0d %s: %0d errors, disp_ready low for %0d cycles",
			num, name, n_errors + tb_errors - err0, low_cycles - low0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'he3f4));
		reset      = 1'b1;
		fu_ready   = 1'b0;
		disp0      = '0;
		disp1      = '0;
		cdb0       = '0;
		cdb1       = '0;
		tb_errors  = 0;
		rob_busy   = '0;
		tag_busy   = '0;
		next_rob   = 0;
		accept_q   = 1'b0;
		accept_rob = '0;
		pct_disp   = 0;
		pct_tag    = 0;
		pct_cdb    = 0;
		pct_fu     = 100;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		run_phase(1, "reset state", 4, 0, 0, 0, 100, 1'b0);
		run_phase(2, "immediate operands", 30, 40, 0, 0, 100, 1'b0);
		run_phase(3, "CDB wakeup", 60, 30, 80, 20, 100, 1'b0);
		run_phase(4, "back-pressure", 80, 40, 30, 40, 15, 1'b0);
		run_phase(5, "random fill", 600, 90, 60, 20, 50, 1'b1);
		total = n_errors + tb_errors + dut0.asserts0.fail_count;
		$display("counts: %0d dispatched, %0d issued, %0d errors", n_disp, n_issue, total);
		if (total == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Whole-run limit in case a phase stalls
	initial
	begin
		#100000;
		$display("error: simulation time limit reached before the tests finished");
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+src
src/rs_pkg.sv
src/rs_entry.sv
src/rs_alloc.sv
src/rs_issue.sv
src/rs_top.sv
tb/rs_checker.sv
tb/rs_asserts.sv
tb/rs_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rs_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
